// File: hdl/video_pkg.sv
// Video subsystem shared geometry, CPU address map, register indices and types.
package video_pkg;

	// =========================================================================
	// Screen geometry.
	// =========================================================================
	localparam int ACTIVE_WIDTH = 64;
	localparam int ACTIVE_HEIGHT = 48;
	localparam int HBLANK_CYCLES = 48;
	localparam int VBLANK_LINES = 4;

	// Line buffer, palette and write buffer sizes.
	localparam int MAX_PITCH = 64;
	localparam int LINE_WORDS = MAX_PITCH / 4;
	localparam int LINE_ADDR_W = $clog2(LINE_WORDS);
	localparam int PALETTE_SIZE = 256;
	localparam int WB_DEPTH = 16;

	// CPU regions, address bits 23:20.
	localparam logic [3:0] REGION_PALETTE = 4'hE;
	localparam logic [3:0] REGION_CONTROL = 4'hF;

	// Control registers, address bits 4:2.
	localparam logic [2:0] REG_READ_OFFSET = 3'd0;
	localparam logic [2:0] REG_PITCH = 3'd1;
	localparam logic [2:0] REG_SKIP = 3'd2;
	localparam logic [2:0] REG_SKIP_X = 3'd3;
	localparam logic [2:0] REG_SKIP_Y = 3'd4;
	localparam logic [2:0] REG_USE_PALETTE = 3'd5;
	localparam logic [2:0] REG_FRAME_COUNT = 3'd6;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [10:0] pos_t;
	typedef logic [23:0] color_t;
	typedef logic [7:0] pal_index_t;
	typedef logic [23:0] vram_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		END_PALETTE_WRITE,
		END_VRAM_ACCESS,
		ACCESS_CONTROL,
		WAIT_REQUEST_END
	} cpu_state_t;

endpackage

// File: hdl/bram_1r1w.sv
// Block RAM with one registered read port and one write port.
`timescale 1ns/1ps

module bram_1r1w #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input logic i_clock,

	// Read port.
	input logic [$clog2(DEPTH)-1:0] i_rd_address,
	output logic [WIDTH-1:0] o_rd_data,

	// Write port.
	input logic i_wr_request,
	input logic [$clog2(DEPTH)-1:0] i_wr_address,
	input logic [WIDTH-1:0] i_wr_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Read before write on a shared address.
	always_ff @(posedge i_clock) begin
		if (i_wr_request) begin
			mem[i_wr_address] <= i_wr_data;
		end
		o_rd_data <= mem[i_rd_address];
	end

endmodule

// File: hdl/vram_write_buffer.sv
// Write FIFO between the CPU and VRAM port A, with reads held behind queued writes.
`timescale 1ns/1ps

module vram_write_buffer #(
	parameter int DEPTH = 16
) (
	input logic i_clock,
	input logic i_rst_n,

	// CPU side.
	input logic i_request,
	input logic i_rw,
	input video_pkg::vram_addr_t i_address,
	input video_pkg::data_t i_wdata,
	output logic o_ready,
	output video_pkg::data_t o_rdata,

	// VRAM bus side.
	output logic o_bus_request,
	output logic o_bus_rw,
	output video_pkg::vram_addr_t o_bus_address,
	output video_pkg::data_t o_bus_wdata,
	input video_pkg::data_t i_bus_rdata,
	input logic i_bus_ready
);
	import video_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	vram_addr_t fifo_address [DEPTH];
	data_t fifo_wdata [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic full;
	logic push;
	logic pop;
	logic bus_done;
	logic read_start;

	assign full = (count == (PTR_W + 1)'(DEPTH));
	assign push = i_request && i_rw && !o_ready && !full;
	assign bus_done = o_bus_request && i_bus_ready;
	assign pop = bus_done && o_bus_rw;

	// Reads go out only once every queued write has completed.
	assign read_start = i_request && !i_rw && !o_ready && (count == '0) && !o_bus_request;

	always_ff @(posedge i_clock) begin
		if (push) begin
			fifo_address[wr_ptr] <= i_address;
			fifo_wdata[wr_ptr] <= i_wdata;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_ready <= 1'b0;
			o_rdata <= '0;
			o_bus_request <= 1'b0;
			o_bus_rw <= 1'b0;
			o_bus_address <= '0;
			o_bus_wdata <= '0;
		end else begin
			o_ready <= push || (bus_done && !o_bus_rw);
			if (bus_done && !o_bus_rw) begin
				o_rdata <= i_bus_rdata;
			end

			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// One bus transfer at a time.
			if (bus_done) begin
				o_bus_request <= 1'b0;
			end else if (read_start) begin
				o_bus_request <= 1'b1;
				o_bus_rw <= 1'b0;
				o_bus_address <= i_address;
			end else if (!o_bus_request && (count != '0)) begin
				o_bus_request <= 1'b1;
				o_bus_rw <= 1'b1;
				o_bus_address <= fifo_address[rd_ptr];
				o_bus_wdata <= fifo_wdata[rd_ptr];
			end
		end
	end

	a_request_after_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_request) |-> !o_ready)
		else $error("write buffer request rose while ready was high");

	a_no_push_when_full: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		full && !pop |=> count == (PTR_W + 1)'(DEPTH))
		else $error("write buffer accepted an entry while full");

endmodule

// File: hdl/video_timing_gen.sv
// Video timing generator for pixel position and horizontal and vertical blanking.
`timescale 1ns/1ps

module video_timing_gen (
	input logic i_clock,
	input logic i_rst_n,
	output video_pkg::pos_t o_pos_x,
	output video_pkg::pos_t o_pos_y,
	output logic o_hblank,
	output logic o_vblank,
	output logic o_active
);
	import video_pkg::*;

	pos_t h_count;
	pos_t line_count;

	// Each line is hblank first, then the active pixels.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			h_count <= '0;
			line_count <= '0;
		end else begin
			if (h_count == pos_t'(HBLANK_CYCLES + ACTIVE_WIDTH - 1)) begin
				h_count <= '0;
				if (line_count == pos_t'(ACTIVE_HEIGHT + VBLANK_LINES - 1)) begin
					line_count <= '0;
				end else begin
					line_count <= line_count + 1'b1;
				end
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	assign o_hblank = (h_count < pos_t'(HBLANK_CYCLES));
	assign o_vblank = (line_count >= pos_t'(ACTIVE_HEIGHT));
	assign o_active = !o_hblank && !o_vblank;

	// X parks at 0 through hblank.
	assign o_pos_x = o_hblank ? '0 : h_count - pos_t'(HBLANK_CYCLES);
	assign o_pos_y = line_count;

endmodule

// File: hdl/video_controller.sv
// Video controller with CPU register access, VRAM line fetch and palette pixel stream.
`timescale 1ns/1ps

module video_controller (
	input logic i_clock,
	input logic i_rst_n,

	// CPU.
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	output video_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,

	// Video timing.
	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::pos_t i_video_pos_x,
	input video_pkg::pos_t i_video_pos_y,

	// Pixel out.
	output video_pkg::data_t o_pixel,
	output logic o_pixel_valid,

	// VRAM port A.
	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::vram_addr_t o_vram_pa_address,
	output video_pkg::data_t o_vram_pa_wdata,
	input video_pkg::data_t i_vram_pa_rdata,
	input logic i_vram_pa_ready,

	// VRAM port B.
	output logic o_vram_pb_request,
	output logic o_vram_pb_rw,
	output video_pkg::vram_addr_t o_vram_pb_address,
	input video_pkg::data_t i_vram_pb_rdata,
	input logic i_vram_pb_ready,

	// Overlay.
	output video_pkg::pos_t o_overlay_x,
	output video_pkg::pos_t o_overlay_y,
	input video_pkg::pal_index_t i_overlay_data,
	input logic i_overlay_mask
);
	import video_pkg::*;

	// Control registers.
	data_t vram_read_offset;
	data_t vram_pitch;
	logic [1:0] vram_skip;
	pos_t vram_skip_x;
	pos_t vram_skip_y;
	logic vram_use_palette;
	data_t frame_counter;

	cpu_state_t state;

	logic pal_wr_request;
	pal_index_t pal_rd_address;
	color_t pal_rd_data;

	logic wb_request;
	logic wb_ready;
	data_t wb_rdata;

	// =========================================================================
	// CPU access
	// =========================================================================

	// The CPU holds address and data until ready, so both ports read them direct.
	assign pal_wr_request = (state == END_PALETTE_WRITE) && i_cpu_rw;
	assign wb_request = (state == END_VRAM_ACCESS);

	bram_1r1w #(
		.WIDTH(24),
		.DEPTH(PALETTE_SIZE)
	) palette (
		.i_clock(i_clock),
		.i_rd_address(pal_rd_address),
		.o_rd_data(pal_rd_data),
		.i_wr_request(pal_wr_request),
		.i_wr_address(i_cpu_address[9:2]),
		.i_wr_data(i_cpu_wdata[23:0])
	);

	vram_write_buffer #(
		.DEPTH(WB_DEPTH)
	) write_buffer (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(wb_request),
		.i_rw(i_cpu_rw),
		.i_address(i_cpu_address[23:0]),
		.i_wdata(i_cpu_wdata),
		.o_ready(wb_ready),
		.o_rdata(wb_rdata),
		.o_bus_request(o_vram_pa_request),
		.o_bus_rw(o_vram_pa_rw),
		.o_bus_address(o_vram_pa_address),
		.o_bus_wdata(o_vram_pa_wdata),
		.i_bus_rdata(i_vram_pa_rdata),
		.i_bus_ready(i_vram_pa_ready)
	);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_cpu_ready <= 1'b0;
			o_cpu_rdata <= '0;
			vram_read_offset <= '0;
			vram_pitch <= data_t'(MAX_PITCH);
			vram_skip <= 2'b00;
			vram_skip_x <= '0;
			vram_skip_y <= '0;
			vram_use_palette <= 1'b1;
		end else begin
			o_cpu_ready <= 1'b0;
			case (state)
				IDLE: begin
					if (i_cpu_request) begin
						if (i_cpu_address[23:20] == REGION_PALETTE) begin
							state <= END_PALETTE_WRITE;
						end else if (i_cpu_address[23:20] == REGION_CONTROL) begin
							state <= ACCESS_CONTROL;
						end else begin
							state <= END_VRAM_ACCESS;
						end
					end
				end
				END_PALETTE_WRITE: begin
					o_cpu_ready <= 1'b1;
					state <= WAIT_REQUEST_END;
				end
				END_VRAM_ACCESS: begin
					if (wb_ready) begin
						o_cpu_ready <= 1'b1;
						o_cpu_rdata <= wb_rdata;
						state <= WAIT_REQUEST_END;
					end
				end
				ACCESS_CONTROL: begin
					if (i_cpu_rw) begin
						case (i_cpu_address[4:2])
							REG_READ_OFFSET: vram_read_offset <= i_cpu_wdata;
							REG_PITCH: vram_pitch <= i_cpu_wdata;
							REG_SKIP: vram_skip <= i_cpu_wdata[1:0];
							REG_SKIP_X: vram_skip_x <= i_cpu_wdata[10:0];
							REG_SKIP_Y: vram_skip_y <= i_cpu_wdata[10:0];
							REG_USE_PALETTE: vram_use_palette <= |i_cpu_wdata;
							default: ;
						endcase
					end else begin
						case (i_cpu_address[4:2])
							REG_READ_OFFSET: o_cpu_rdata <= vram_read_offset;
							REG_PITCH: o_cpu_rdata <= vram_pitch;
							REG_SKIP: o_cpu_rdata <= data_t'(vram_skip);
							REG_SKIP_X: o_cpu_rdata <= data_t'(vram_skip_x);
							REG_SKIP_Y: o_cpu_rdata <= data_t'(vram_skip_y);
							REG_USE_PALETTE: o_cpu_rdata <= data_t'(vram_use_palette);
							REG_FRAME_COUNT: o_cpu_rdata <= frame_counter;
							default: o_cpu_rdata <= '0;
						endcase
					end
					o_cpu_ready <= 1'b1;
					state <= WAIT_REQUEST_END;
				end
				// Ready is held until the CPU lets go.
				WAIT_REQUEST_END: begin
					o_cpu_ready <= i_cpu_request;
					if (!i_cpu_request) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// =========================================================================
	// Window and line fetch
	// =========================================================================

	pos_t rel_x;
	pos_t rel_y;
	pos_t col_x;
	pos_t src_row;
	logic x_in_window;
	logic y_in_window;
	data_t row_base;
	logic hblank_q;
	logic vblank_q;
	pos_t last_row;
	logic last_row_valid;
	logic [LINE_ADDR_W-1:0] fetch_word;
	logic [LINE_ADDR_W-1:0] last_word;

	always_comb begin
		rel_x = i_video_pos_x - vram_skip_x;
		rel_y = i_video_pos_y - vram_skip_y;
		col_x = vram_skip[0] ? (rel_x >> 1) : rel_x;
		src_row = vram_skip[1] ? (rel_y >> 1) : rel_y;
		x_in_window = (i_video_pos_x >= vram_skip_x) &&
			(i_video_pos_x < pos_t'(ACTIVE_WIDTH) - vram_skip_x);
		y_in_window = (i_video_pos_y >= vram_skip_y) &&
			(i_video_pos_y < pos_t'(ACTIVE_HEIGHT) - vram_skip_y);
		row_base = vram_read_offset + data_t'(src_row) * vram_pitch;
	end

	assign o_overlay_x = col_x;
	assign o_overlay_y = src_row;

	// Pitch of MAX_PITCH wraps to zero here, giving the full buffer.
	assign last_word = vram_pitch[LINE_ADDR_W+1:2] - 1'b1;
	assign o_vram_pb_rw = 1'b0;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hblank_q <= 1'b0;
			vblank_q <= 1'b0;
			last_row <= '0;
			last_row_valid <= 1'b0;
			fetch_word <= '0;
			frame_counter <= '0;
			o_vram_pb_request <= 1'b0;
			o_vram_pb_address <= '0;
		end else begin
			hblank_q <= i_video_hblank;
			vblank_q <= i_video_vblank;

			if (i_video_vblank && !vblank_q) begin
				last_row_valid <= 1'b0;
				frame_counter <= frame_counter + 1'b1;
			end

			if (o_vram_pb_request && i_vram_pb_ready) begin
				fetch_word <= fetch_word + 1'b1;
				if (fetch_word == last_word) begin
					o_vram_pb_request <= 1'b0;
				end else begin
					o_vram_pb_address <= o_vram_pb_address + 24'd4;
				end
			end

			// A repeated source row keeps the buffer from the line before.
			if (i_video_hblank && !hblank_q && !i_video_vblank && y_in_window &&
					(!last_row_valid || src_row != last_row)) begin
				last_row <= src_row;
				last_row_valid <= 1'b1;
				fetch_word <= '0;
				o_vram_pb_address <= vram_addr_t'(row_base);
				o_vram_pb_request <= 1'b1;
			end
		end
	end

	// =========================================================================
	// Pixel stream
	// =========================================================================

	logic [LINE_ADDR_W-1:0] line_rd_address;
	data_t line_rd_data;
	logic active;
	logic s1_valid;
	logic s1_window;
	logic [1:0] s1_byte;
	logic s1_ovl_mask;
	pal_index_t s1_ovl_data;
	pal_index_t line_byte;
	logic s2_valid;
	logic s2_window;
	data_t s2_word;

	bram_1r1w #(
		.WIDTH(32),
		.DEPTH(LINE_WORDS)
	) line_buffer (
		.i_clock(i_clock),
		.i_rd_address(line_rd_address),
		.o_rd_data(line_rd_data),
		.i_wr_request(o_vram_pb_request && i_vram_pb_ready),
		.i_wr_address(fetch_word),
		.i_wr_data(i_vram_pb_rdata)
	);

	assign active = !i_video_hblank && !i_video_vblank;
	assign line_rd_address = vram_use_palette ? col_x[LINE_ADDR_W+1:2] :
		col_x[LINE_ADDR_W-1:0];

	// Stage two, byte select or overlay into the palette.
	assign line_byte = line_rd_data[{s1_byte, 3'b000} +: 8];
	assign pal_rd_address = s1_ovl_mask ? s1_ovl_data : line_byte;

	always_ff @(posedge i_clock) begin
		s1_byte <= col_x[1:0];
		s1_ovl_mask <= i_overlay_mask;
		s1_ovl_data <= i_overlay_data;
		// Direct words wait one stage to match the palette read.
		s2_word <= line_rd_data;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			s1_window <= 1'b0;
			s2_valid <= 1'b0;
			s2_window <= 1'b0;
			o_pixel_valid <= 1'b0;
			o_pixel <= '0;
		end else begin
			s1_valid <= active;
			s1_window <= active && x_in_window && y_in_window;
			s2_valid <= s1_valid;
			s2_window <= s1_window;
			o_pixel_valid <= s2_valid;
			if (s2_valid && s2_window) begin
				o_pixel <= vram_use_palette ? {8'h00, pal_rd_data} : s2_word;
			end else begin
				o_pixel <= '0;
			end
		end
	end

	a_fetch_in_hblank: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_vram_pb_request |-> i_video_hblank)
		else $error("line fetch still running in the active part of the line");

	a_state_legal: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		state inside {IDLE, END_PALETTE_WRITE, END_VRAM_ACCESS, ACCESS_CONTROL,
			WAIT_REQUEST_END})
		else $error("CPU FSM left its legal states");

endmodule

// File: hdl/video_subsystem.sv
// Video subsystem top level joining the timing generator and the video controller.
`timescale 1ns/1ps

module video_subsystem (
	input logic i_clock,
	input logic i_rst_n,

	// CPU.
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	output video_pkg::data_t o_cpu_rdata,
	output logic o_cpu_ready,

	// Pixel out.
	output video_pkg::data_t o_pixel,
	output logic o_pixel_valid,

	// VRAM port A.
	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::vram_addr_t o_vram_pa_address,
	output video_pkg::data_t o_vram_pa_wdata,
	input video_pkg::data_t i_vram_pa_rdata,
	input logic i_vram_pa_ready,

	// VRAM port B.
	output logic o_vram_pb_request,
	output logic o_vram_pb_rw,
	output video_pkg::vram_addr_t o_vram_pb_address,
	input video_pkg::data_t i_vram_pb_rdata,
	input logic i_vram_pb_ready,

	// Overlay.
	output video_pkg::pos_t o_overlay_x,
	output video_pkg::pos_t o_overlay_y,
	input video_pkg::pal_index_t i_overlay_data,
	input logic i_overlay_mask
);
	import video_pkg::*;

	pos_t pos_x;
	pos_t pos_y;
	logic hblank;
	logic vblank;

	video_timing_gen timing (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.o_pos_x(pos_x),
		.o_pos_y(pos_y),
		.o_hblank(hblank),
		.o_vblank(vblank),
		.o_active()
	);

	video_controller controller (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.i_video_hblank(hblank),
		.i_video_vblank(vblank),
		.i_video_pos_x(pos_x),
		.i_video_pos_y(pos_y),
		.o_pixel(o_pixel),
		.o_pixel_valid(o_pixel_valid),
		.o_vram_pa_request(o_vram_pa_request),
		.o_vram_pa_rw(o_vram_pa_rw),
		.o_vram_pa_address(o_vram_pa_address),
		.o_vram_pa_wdata(o_vram_pa_wdata),
		.i_vram_pa_rdata(i_vram_pa_rdata),
		.i_vram_pa_ready(i_vram_pa_ready),
		.o_vram_pb_request(o_vram_pb_request),
		.o_vram_pb_rw(o_vram_pb_rw),
		.o_vram_pb_address(o_vram_pb_address),
		.i_vram_pb_rdata(i_vram_pb_rdata),
		.i_vram_pb_ready(i_vram_pb_ready),
		.o_overlay_x(o_overlay_x),
		.o_overlay_y(o_overlay_y),
		.i_overlay_data(i_overlay_data),
		.i_overlay_mask(i_overlay_mask)
	);

endmodule

// File: dv/video_checker.sv
// Video subsystem checker comparing pixels, overlay position and CPU reads with a model.
`timescale 1ns/1ps

module video_checker (
	input logic i_clock,
	input logic i_rst_n,

	// Watched CPU bus.
	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::data_t i_cpu_wdata,
	input video_pkg::data_t i_cpu_rdata,
	input logic i_cpu_ready,

	// Pixel and overlay outputs of the DUT.
	input video_pkg::data_t i_pixel,
	input logic i_pixel_valid,
	input video_pkg::pos_t i_overlay_x,
	input video_pkg::pos_t i_overlay_y,

	// Line fetch port of the DUT.
	input logic i_vram_pb_request,
	input logic i_vram_pb_rw,

	input logic i_check_en,
	output logic o_frame_done,
	output int o_error_count,
	output int o_checked_frames
);
	import video_pkg::*;

	localparam int FRAME_PIXELS = ACTIVE_WIDTH * ACTIVE_HEIGHT;

	logic [7:0] vram [4096];
	color_t palette [PALETTE_SIZE];
	int offset;
	int pitch;
	logic [1:0] skip;
	int skip_x;
	int skip_y;
	logic use_pal;
	int frames;
	int pix_index;
	logic frame_check;
	logic ready_q;
	pos_t ovx_hist [3];
	pos_t ovy_hist [3];

	initial begin
		for (int i = 0; i < 4096; i++) begin
			vram[i] = 8'h00;
		end
		o_error_count = 0;
	end

	function automatic data_t vram_word(input logic [11:0] a);
		return {vram[a + 12'd3], vram[a + 12'd2], vram[a + 12'd1], vram[a]};
	endfunction

	task automatic compare(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			o_error_count = o_error_count + 1;
		end
	endtask

	// ========================================================================
	// CPU access model
	// ========================================================================
	task automatic bus_event();
		logic [11:0] a;
		a = i_cpu_address[11:0];
		if (i_cpu_address[23:20] == REGION_PALETTE) begin
			if (i_cpu_rw) begin
				palette[i_cpu_address[9:2]] = i_cpu_wdata[23:0];
			end
		end else if (i_cpu_address[23:20] == REGION_CONTROL) begin
			if (i_cpu_rw) begin
				case (i_cpu_address[4:2])
					REG_READ_OFFSET: offset = int'(i_cpu_wdata);
					REG_PITCH: pitch = int'(i_cpu_wdata);
					REG_SKIP: skip = i_cpu_wdata[1:0];
					REG_SKIP_X: skip_x = int'(i_cpu_wdata[10:0]);
					REG_SKIP_Y: skip_y = int'(i_cpu_wdata[10:0]);
					REG_USE_PALETTE: use_pal = |i_cpu_wdata;
					default: ;
				endcase
			end else if (i_cpu_address[4:2] == REG_FRAME_COUNT) begin
				compare("o_cpu_rdata", data_t'(frames), i_cpu_rdata);
			end
		end else if (i_cpu_rw) begin
			for (int k = 0; k < 4; k++) begin
				vram[a + 12'(k)] = i_cpu_wdata[8*k +: 8];
			end
		end else begin
			compare("o_cpu_rdata", vram_word(a), i_cpu_rdata);
		end
	endtask

	// ========================================================================
	// Pixel model
	// ========================================================================
	task automatic check_pixel(input int x, input int y);
		int col;
		int row;
		logic [7:0] idx;
		data_t exp;
		exp = '0;
		if (x >= skip_x && x < ACTIVE_WIDTH - skip_x &&
				y >= skip_y && y < ACTIVE_HEIGHT - skip_y) begin
			col = (x - skip_x) >> skip[0];
			row = (y - skip_y) >> skip[1];
			compare("o_overlay_x", data_t'(col), data_t'(ovx_hist[2]));
			compare("o_overlay_y", data_t'(row), data_t'(ovy_hist[2]));
			if (use_pal) begin
				// Overlay wins where its mask is up.
				if ((col + row) % 16 == 0) begin
					idx = 8'(col ^ row);
				end else begin
					idx = vram[12'(offset + row * pitch + col)];
				end
				exp = {8'h00, palette[idx]};
			end else begin
				exp = vram_word(12'(offset + row * pitch + 4 * col));
			end
		end
		compare("o_pixel", exp, i_pixel);
	endtask

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			offset = 0;
			pitch = MAX_PITCH;
			skip = 2'b00;
			skip_x = 0;
			skip_y = 0;
			use_pal = 1'b1;
			frames = 0;
			pix_index = 0;
			frame_check = 1'b0;
			o_checked_frames = 0;
			ready_q <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			ready_q <= i_cpu_ready;
			o_frame_done <= 1'b0;
			// Overlay ports lead the pixel by three cycles.
			ovx_hist[0] <= i_overlay_x;
			ovx_hist[1] <= ovx_hist[0];
			ovx_hist[2] <= ovx_hist[1];
			ovy_hist[0] <= i_overlay_y;
			ovy_hist[1] <= ovy_hist[0];
			ovy_hist[2] <= ovy_hist[1];
			// Line fetch only ever reads.
			if (i_vram_pb_request) begin
				compare("o_vram_pb_rw", '0, data_t'(i_vram_pb_rw));
			end
			if (i_cpu_request && i_cpu_ready && !ready_q) begin
				bus_event();
			end
			if (i_pixel_valid) begin
				if (pix_index == 0) begin
					frame_check = i_check_en;
				end
				if (frame_check) begin
					check_pixel(pix_index % ACTIVE_WIDTH, pix_index / ACTIVE_WIDTH);
				end
				if (pix_index == FRAME_PIXELS - 1) begin
					pix_index = 0;
					frames = frames + 1;
					if (frame_check) begin
						o_checked_frames = o_checked_frames + 1;
					end
					o_frame_done <= 1'b1;
				end else begin
					pix_index = pix_index + 1;
				end
			end
		end
	end

endmodule

// File: dv/tb_video_subsystem.sv
// Video subsystem testbench with CPU traffic, VRAM and overlay models and a watchdog.
`timescale 1ns/1ps

module tb_video_subsystem;
	import video_pkg::*;

	localparam int TEST_FRAMES = 6;
	localparam int SETUP_FRAMES = 4;
	localparam int FRAME_CYCLES = (HBLANK_CYCLES + ACTIVE_WIDTH) * (ACTIVE_HEIGHT + VBLANK_LINES);
	localparam int WATCHDOG_NS = (TEST_FRAMES + SETUP_FRAMES + 1) * FRAME_CYCLES * 2 * 10;

	logic clock;
	logic rst_n;
	logic cpu_request;
	logic cpu_rw;
	addr_t cpu_address;
	data_t cpu_wdata;
	data_t cpu_rdata;
	logic cpu_ready;
	data_t pixel;
	logic pixel_valid;
	logic pa_request;
	logic pa_rw;
	vram_addr_t pa_address;
	data_t pa_wdata;
	data_t pa_rdata;
	logic pa_ready;
	logic pb_request;
	logic pb_rw;
	vram_addr_t pb_address;
	data_t pb_rdata;
	logic pb_ready;
	pos_t overlay_x;
	pos_t overlay_y;
	pal_index_t overlay_data;
	logic overlay_mask;
	logic check_en;
	logic frame_done;
	int error_count;
	int checked_frames;
	logic [7:0] vram_mem [4096];
	int pa_wait;

	video_subsystem i_dut (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_cpu_request(cpu_request), .i_cpu_rw(cpu_rw),
		.i_cpu_address(cpu_address), .i_cpu_wdata(cpu_wdata),
		.o_cpu_rdata(cpu_rdata), .o_cpu_ready(cpu_ready),
		.o_pixel(pixel), .o_pixel_valid(pixel_valid),
		.o_vram_pa_request(pa_request), .o_vram_pa_rw(pa_rw),
		.o_vram_pa_address(pa_address), .o_vram_pa_wdata(pa_wdata),
		.i_vram_pa_rdata(pa_rdata), .i_vram_pa_ready(pa_ready),
		.o_vram_pb_request(pb_request), .o_vram_pb_rw(pb_rw),
		.o_vram_pb_address(pb_address), .i_vram_pb_rdata(pb_rdata),
		.i_vram_pb_ready(pb_ready),
		.o_overlay_x(overlay_x), .o_overlay_y(overlay_y),
		.i_overlay_data(overlay_data), .i_overlay_mask(overlay_mask)
	);

	video_checker i_checker (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_cpu_request(cpu_request), .i_cpu_rw(cpu_rw),
		.i_cpu_address(cpu_address), .i_cpu_wdata(cpu_wdata),
		.i_cpu_rdata(cpu_rdata), .i_cpu_ready(cpu_ready),
		.i_pixel(pixel), .i_pixel_valid(pixel_valid),
		.i_overlay_x(overlay_x), .i_overlay_y(overlay_y),
		.i_vram_pb_request(pb_request), .i_vram_pb_rw(pb_rw),
		.i_check_en(check_en), .o_frame_done(frame_done),
		.o_error_count(error_count), .o_checked_frames(checked_frames)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Overlay source answers in the same cycle.
	always_comb begin
		overlay_mask = ((overlay_x + overlay_y) & 11'd15) == 11'd0;
		overlay_data = overlay_x[7:0] ^ overlay_y[7:0];
	end

	// ========================================================================
	// VRAM model with port B answering a cycle after each address.
	// ========================================================================
	function automatic data_t read_word(input logic [11:0] a);
		return {vram_mem[a + 12'd3], vram_mem[a + 12'd2], vram_mem[a + 12'd1], vram_mem[a]};
	endfunction

	always @(posedge clock) begin
		pb_ready <= pb_request && !pb_ready;
		if (pb_request && !pb_ready) begin
			pb_rdata <= read_word(pb_address[11:0]);
		end
		if (pa_ready) begin
			pa_ready <= 1'b0;
		end else if (pa_request) begin
			if (pa_wait == 0) begin
				pa_wait <= 1 + int'($urandom % 3);
			end else if (pa_wait == 1) begin
				pa_wait <= 0;
				pa_ready <= 1'b1;
				if (pa_rw) begin
					for (int k = 0; k < 4; k++) begin
						vram_mem[pa_address[11:0] + 12'(k)] = pa_wdata[8*k +: 8];
					end
				end else begin
					pa_rdata <= read_word(pa_address[11:0]);
				end
			end else begin
				pa_wait <= pa_wait - 1;
			end
		end
	end

	task automatic cpu_access(input logic rw, input addr_t a, input data_t d, output data_t r);
		@(posedge clock);
		cpu_request <= 1'b1;
		cpu_rw <= rw;
		cpu_address <= a;
		cpu_wdata <= d;
		do @(posedge clock); while (!cpu_ready);
		r = cpu_rdata;
		cpu_request <= 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] idx, input data_t d);
		data_t unused;
		cpu_access(1'b1, 32'h00F0_0000 + (32'(idx) << 2), d, unused);
	endtask

	initial begin
		data_t rdata;
		addr_t addrs[$];
		addr_t a;
		data_t offset;
		void'($urandom(66));
		for (int i = 0; i < 4096; i++) begin
			vram_mem[i] = 8'h00;
		end
		rst_n = 1'b0;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		pa_rdata = '0;
		pa_ready = 1'b0;
		pb_rdata = '0;
		pb_ready = 1'b0;
		pa_wait = 0;
		check_en = 1'b0;
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;

		// Writes to a small range, so some addresses repeat.
		for (int i = 0; i < 24; i++) begin
			a = 32'($urandom % 64) << 2;
			addrs.push_back(a);
			cpu_access(1'b1, a, $urandom, rdata);
		end
		foreach (addrs[i]) begin
			cpu_access(1'b0, addrs[i], '0, rdata);
		end

		// Random palette and frame contents.
		for (int i = 0; i < PALETTE_SIZE; i++) begin
			cpu_access(1'b1, 32'h00E0_0000 + (32'(i) << 2), $urandom, rdata);
		end
		for (int i = 0; i < 1024; i++) begin
			cpu_access(1'b1, 32'(i) << 2, $urandom, rdata);
		end
		cpu_access(1'b0, '0, '0, rdata);

		// ====================================================================
		// Each vblank writes the setting for the next frame.
		// ====================================================================
		for (int f = 0; f < TEST_FRAMES; f++) begin
			@(posedge clock iff frame_done);
			offset = (f == 0) ? '0 : 32'($urandom % 256) << 2;
			write_reg(REG_READ_OFFSET, offset);
			if (f == 0) begin
				write_reg(REG_SKIP, '0);
				write_reg(REG_SKIP_X, '0);
				write_reg(REG_SKIP_Y, '0);
				write_reg(REG_USE_PALETTE, 32'd1);
			end else if (f == TEST_FRAMES - 2) begin
				// Doubled 32 pixel window keeps the direct columns inside the buffer.
				write_reg(REG_SKIP, 32'd1 | ((32'($urandom % 2)) << 1));
				write_reg(REG_SKIP_X, 32'd16);
				write_reg(REG_SKIP_Y, 32'($urandom % 12));
				write_reg(REG_USE_PALETTE, '0);
			end else begin
				write_reg(REG_SKIP, 32'($urandom % 4));
				write_reg(REG_SKIP_X, 32'($urandom % 32));
				write_reg(REG_SKIP_Y, 32'($urandom % 24));
				write_reg(REG_USE_PALETTE, 32'd1);
			end
			cpu_access(1'b0, 32'h00F0_0000 + (32'(REG_FRAME_COUNT) << 2), '0, rdata);
			check_en <= 1'b1;
		end
		@(posedge clock iff frame_done);
		cpu_access(1'b0, 32'h00F0_0000 + (32'(REG_FRAME_COUNT) << 2), '0, rdata);
		repeat (2) @(posedge clock);

		if (checked_frames != TEST_FRAMES) begin
			$display("Only %0d of %0d frames were checked", checked_frames, TEST_FRAMES);
		end
		$display("errors: %0d", error_count);
		if (error_count == 0 && checked_frames == TEST_FRAMES) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the run went past its frame budget");
		$display("tests failed");
		$finish;
	end

endmodule

// File: flist.f
hdl/video_pkg.sv
hdl/bram_1r1w.sv
hdl/vram_write_buffer.sv
hdl/video_timing_gen.sv
hdl/video_controller.sv
hdl/video_subsystem.sv
dv/video_checker.sv
dv/tb_video_subsystem.sv

// File: Makefile
# Verilator build for the video subsystem.

VERILATOR ?= verilator
FLIST ?= flist.f
TOP ?= tb_video_subsystem
LINT_TOP ?= video_subsystem
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
